// ==== verilog.f ====
verilog/mode_sweep_pkg.sv
verilog/lane_stage_if.sv
verilog/interval_classifier.sv
verilog/interval_histogram.sv
verilog/mode_tracker.sv
verilog/coef_datapath.sv
verilog/step_timer.sv
verilog/sweep_fsm.sv
verilog/mode_sweep_top.sv
bench/tb_clock_gen.sv
bench/tb_mode_sweep.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the mode sweep testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_mode_sweep -o tb_mode_sweep \
    && ./obj_dir/tb_mode_sweep > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat "$LOG"
grep -q "Done: errors found" "$LOG" && { echo "FAILED"; exit 1; } || { echo "PASSED"; exit 0; }

// ==== bench/tb_mode_sweep.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mode_sweep import mode_sweep_pkg::*; ();

    localparam logic [31:0] SEED     = 32'h286b_5ace;
    localparam int          NUM_RUNS = 5;

    // One expected output beat
    typedef struct packed {
        logic                            valid;
        logic [LANES-1:0][INTERVALS-1:0] interval;
        logic [LANES-1:0]                u_add;
        logic [LANES-1:0][INTERVALS-1:0] mode;
        logic [LANES-1:0][CNT_W-1:0]     max_cnt;
        lane_data_t                      alpha;
        lane_data_t                      beta;
        lane_data_t                      alpha_s;
    } expect_t;

    logic                            clk;
    logic                            rst;
    logic                            start;
    cnt_t                            j_size;
    logic                            sample_valid;
    lane_data_t                      s;
    lane_data_t                      a_acc;
    lane_data_t                      a_pos;
    lane_data_t                      b_acc;
    lane_data_t                      b_pos;
    logic                            out_valid;
    logic [LANES-1:0][INTERVALS-1:0] interval;
    lane_data_t                      alpha;
    lane_data_t                      beta;
    lane_data_t                      alpha_s;
    logic [LANES-1:0]                u_add;
    logic [LANES-1:0][INTERVALS-1:0] mode;
    logic [LANES-1:0][CNT_W-1:0]     max_cnt;
    logic                            busy;
    logic                            done;

    int           run_sizes [NUM_RUNS] = '{40, 0, 25, 1, 60};
    logic [31:0]  rng_state;
    int           errors;
    int           checks;
    sweep_state_e m_state;
    int           size_m;
    int           step_m;
    int           drain_m;
    int           hist [LANES][INTERVALS];
    onehot_t      mode_m [LANES];
    int           max_m [LANES];
    expect_t      exp_q [$];

    tb_clock_gen u_clock_gen (
        .CLK_o (clk),
        .RST_o (rst)
    );

    mode_sweep_top #(.INTERVALS(INTERVALS), .CNT_W(CNT_W)) u_mode_sweep_top (
        .CLK_i          (clk),
        .RST_i          (rst),
        .start_i        (start),
        .j_size_i       (j_size),
        .sample_valid_i (sample_valid),
        .s_i            (s),
        .a_acc_i        (a_acc),
        .a_pos_i        (a_pos),
        .b_acc_i        (b_acc),
        .b_pos_i        (b_pos),
        .out_valid_o    (out_valid),
        .interval_o     (interval),
        .alpha_o        (alpha),
        .beta_o         (beta),
        .alpha_s_o      (alpha_s),
        .u_add_o        (u_add),
        .mode_o         (mode),
        .max_cnt_o      (max_cnt),
        .busy_o         (busy),
        .done_o         (done)
    );

    ////////////////////////////////////////////////////////////
    // Random numbers and checking
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic signed [63:0] expected,
                               input logic signed [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s at %0t: expected %0d, actual %0d", name, $time, expected,
                     actual);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    task automatic clear_model();
        for (int l = 0; l < LANES; l++) begin
            for (int n = 0; n < INTERVALS; n++) begin
                hist[l][n] = 0;
            end
            mode_m[l] = '0;
            max_m[l]  = 0;
        end
    endtask

    // Interval, histogram, mode and coefficients of one accepted sample
    task automatic model_lane(input int l, inout expect_t e);
        int    k;
        int    prod;
        logic  mode_hit;
        data_t al;
        data_t be;
        k = (int'(s[l]) >>> 8) + INTERVALS / 2;
        if (k < 0) begin
            k = 0;
        end else if (k > INTERVALS - 1) begin
            k = INTERVALS - 1;
        end
        e.interval[l] = onehot_t'(1) << k;
        // Zeroing uses the mode before this sample counts
        mode_hit = e.interval[l] == mode_m[l];
        hist[l][k]++;
        e.u_add[l] = hist[l][k] > max_m[l];
        if (e.u_add[l]) begin
            mode_m[l] = e.interval[l];
            max_m[l]  = hist[l][k];
        end
        e.mode[l]    = mode_m[l];
        e.max_cnt[l] = cnt_t'(max_m[l]);
        al   = a_acc[l] - a_pos[l];
        be   = b_acc[l] - b_pos[l];
        prod = int'(al) * int'(s[l]);
        e.alpha[l]   = mode_hit ? data_t'(0) : al;
        e.beta[l]    = mode_hit ? data_t'(0) : be;
        e.alpha_s[l] = mode_hit ? data_t'(0) : data_t'(prod >>> 8);
    endtask

    // Sweep sequencing as seen at the next rising edge
    task automatic advance_fsm(input logic accepted);
        case (m_state)
            IDLE, DONE: begin
                if (start) begin
                    m_state = CLEAR;
                    size_m  = int'(j_size);
                    step_m  = 0;
                end
            end
            CLEAR: begin
                clear_model();
                drain_m = 0;
                m_state = (size_m == 0) ? DRAIN : RUN;
            end
            RUN: begin
                if (accepted) begin
                    step_m++;
                    if (step_m == size_m) m_state = DRAIN;
                end
            end
            DRAIN: begin
                if (drain_m == 1) m_state = DONE;
                else drain_m++;
            end
            default: m_state = IDLE;
        endcase
    endtask

    task automatic check_outputs();
        expect_t e;
        e = exp_q.pop_front();
        check_value("busy", m_state inside {CLEAR, RUN, DRAIN}, busy);
        check_value("done", m_state == DONE, done);
        check_value("out_valid", e.valid, out_valid);
        for (int l = 0; l < LANES; l++) begin
            check_value($sformatf("u_add lane %0d", l), e.u_add[l], u_add[l]);
            if (e.valid) begin
                check_value($sformatf("interval lane %0d", l), e.interval[l], interval[l]);
                check_value($sformatf("mode lane %0d", l), e.mode[l], mode[l]);
                check_value($sformatf("max_cnt lane %0d", l), e.max_cnt[l], max_cnt[l]);
                check_value($sformatf("alpha lane %0d", l), e.alpha[l], alpha[l]);
                check_value($sformatf("beta lane %0d", l), e.beta[l], beta[l]);
                check_value($sformatf("alpha_s lane %0d", l), e.alpha_s[l], alpha_s[l]);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // Check the last edge, then drive the next one
    task automatic step_cycle(input logic start_in, input cnt_t size_in);
        expect_t     nxt;
        logic [31:0] r;
        logic        accepted;
        @(negedge clk);
        check_outputs();
        start        = start_in;
        j_size       = start_in ? size_in : cnt_t'(next_rand());
        sample_valid = (next_rand() % 32'd10) < 32'd7;
        for (int l = 0; l < LANES; l++) begin
            // Roughly -6.0 to +5.0 in Q8.8
            r        = next_rand();
            s[l]     = data_t'(int'(r % 32'd2817) - 1536);
            a_acc[l] = data_t'(next_rand());
            a_pos[l] = data_t'(next_rand());
            b_acc[l] = data_t'(next_rand());
            b_pos[l] = data_t'(next_rand());
        end
        accepted  = (m_state == RUN) && sample_valid;
        nxt       = '0;
        nxt.valid = accepted;
        if (accepted) begin
            for (int l = 0; l < LANES; l++) begin
                model_lane(l, nxt);
            end
        end
        exp_q.push_back(nxt);
        advance_fsm(accepted);
    endtask

    task automatic run_sweep(input int size);
        step_cycle(1'b1, cnt_t'(size));
        do begin
            step_cycle(1'b0, '0);
        end while (!done);
        // Strobes while done are ignored
        repeat (3) step_cycle(1'b0, '0);
    endtask

    initial begin
        start        = 1'b0;
        j_size       = '0;
        sample_valid = 1'b0;
        s            = '0;
        a_acc        = '0;
        a_pos        = '0;
        b_acc        = '0;
        b_pos        = '0;
        errors       = 0;
        checks       = 0;
        rng_state    = SEED;
        m_state      = IDLE;
        size_m       = 0;
        step_m       = 0;
        drain_m      = 0;
        clear_model();
        wait (rst == 1'b0);
        for (int l = 0; l < LANES; l++) begin
            check_value($sformatf("reset mode lane %0d", l), 0, mode[l]);
            check_value($sformatf("reset max_cnt lane %0d", l), 0, max_cnt[l]);
        end
        // Two beats in flight, none valid yet
        exp_q.push_back('0);
        exp_q.push_back('0);
        // Strobes before any start
        repeat (6) step_cycle(1'b0, '0);
        foreach (run_sizes[n]) begin
            run_sweep(run_sizes[n]);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog sized from the strobe budget of all runs
    initial begin : watchdog
        int budget;
        budget = 0;
        foreach (run_sizes[n]) begin
            budget += run_sizes[n];
        end
        budget = budget * 4 + 200;
        repeat (budget) @(posedge clk);
        $display("Watchdog expired: sweep did not finish within %0d cycles", budget);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 3
) (
    output logic CLK_o,
    output logic RST_o
);

    initial begin
        CLK_o = 1'b0;
        forever #(HALF_PERIOD) CLK_o = ~CLK_o;
    end

    // Reset held over the first rising edges, released on a falling edge
    initial begin
        RST_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK_o);
        @(negedge CLK_o);
        RST_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verilog/mode_sweep_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mode_sweep_top import mode_sweep_pkg::*; #(
    parameter int INTERVALS = mode_sweep_pkg::INTERVALS,
    parameter int CNT_W     = mode_sweep_pkg::CNT_W
) (
    input  wire logic                       CLK_i,
    input  wire logic                       RST_i,
    input  wire logic                       start_i,
    input  wire logic [CNT_W-1:0]           j_size_i,
    input  wire logic                       sample_valid_i,
    input  wire lane_data_t                 s_i,
    input  wire lane_data_t                 a_acc_i,
    input  wire lane_data_t                 a_pos_i,
    input  wire lane_data_t                 b_acc_i,
    input  wire lane_data_t                 b_pos_i,
    output logic                            out_valid_o,
    output logic [LANES-1:0][INTERVALS-1:0] interval_o,
    output lane_data_t                      alpha_o,
    output lane_data_t                      beta_o,
    output lane_data_t                      alpha_s_o,
    output logic [LANES-1:0]                u_add_o,
    output logic [LANES-1:0][INTERVALS-1:0] mode_o,
    output logic [LANES-1:0][CNT_W-1:0]     max_cnt_o,
    output logic                            busy_o,
    output logic                            done_o
);

    logic                            clear;
    logic                            accept;
    logic                            load;
    logic                            last;
    logic                            zero_size;
    logic                            upd;
    logic [LANES-1:0][CNT_W-1:0]     new_cnt;
    logic [LANES-1:0][INTERVALS-1:0] stage_interval;

    lane_stage_if u_stage [LANES] ();

    ////////////////////////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////////////////////////

    // j_size is taken with a start that the FSM will honour
    assign load = start_i && !busy_o;

    sweep_fsm u_sweep_fsm (
        .CLK_i          (CLK_i),
        .RST_i          (RST_i),
        .start_i        (start_i),
        .sample_valid_i (sample_valid_i),
        .last_i         (last),
        .zero_size_i    (zero_size),
        .clear_o        (clear),
        .accept_o       (accept),
        .busy_o         (busy_o),
        .done_o         (done_o)
    );

    step_timer #(.CNT_W(CNT_W)) u_step_timer (
        .CLK_i       (CLK_i),
        .RST_i       (RST_i),
        .load_i      (load),
        .tick_i      (accept),
        .j_size_i    (j_size_i),
        .last_o      (last),
        .zero_size_o (zero_size)
    );

    ////////////////////////////////////////////////////////////
    // Lane datapath
    ////////////////////////////////////////////////////////////

    interval_classifier #(.INTERVALS(INTERVALS)) u_classifier (
        .CLK_i    (CLK_i),
        .RST_i    (RST_i),
        .accept_i (accept),
        .s_i      (s_i),
        .a_acc_i  (a_acc_i),
        .a_pos_i  (a_pos_i),
        .b_acc_i  (b_acc_i),
        .b_pos_i  (b_pos_i),
        .stage_o  (u_stage)
    );

    interval_histogram #(.INTERVALS(INTERVALS), .CNT_W(CNT_W)) u_histogram (
        .CLK_i     (CLK_i),
        .RST_i     (RST_i),
        .clear_i   (clear),
        .stage_i   (u_stage),
        .new_cnt_o (new_cnt),
        .upd_o     (upd)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_interval
        assign stage_interval[i] = u_stage[i].interval;
    end

    mode_tracker #(.INTERVALS(INTERVALS), .CNT_W(CNT_W)) u_mode_tracker (
        .CLK_i      (CLK_i),
        .RST_i      (RST_i),
        .clear_i    (clear),
        .upd_i      (upd),
        .interval_i (stage_interval),
        .new_cnt_i  (new_cnt),
        .mode_o     (mode_o),
        .max_cnt_o  (max_cnt_o),
        .u_add_o    (u_add_o)
    );

    coef_datapath #(.INTERVALS(INTERVALS)) u_coef_datapath (
        .CLK_i       (CLK_i),
        .RST_i       (RST_i),
        .stage_i     (u_stage),
        .mode_i      (mode_o),
        .alpha_o     (alpha_o),
        .beta_o      (beta_o),
        .alpha_s_o   (alpha_s_o),
        .interval_o  (interval_o),
        .out_valid_o (out_valid_o)
    );

endmodule

`default_nettype wire

// ==== verilog/sweep_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module sweep_fsm import mode_sweep_pkg::*; (
    input  wire logic CLK_i,
    input  wire logic RST_i,
    input  wire logic start_i,
    input  wire logic sample_valid_i,
    input  wire logic last_i,
    input  wire logic zero_size_i,
    output logic      clear_o,
    output logic      accept_o,
    output logic      busy_o,
    output logic      done_o
);

    sweep_state_e state_q;
    sweep_state_e state_d;
    // Second drain cycle
    logic         drain_q;

    ////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE, DONE: begin
                if (start_i) state_d = CLEAR;
            end
            CLEAR: begin
                // Empty run skips straight to drain
                state_d = zero_size_i ? DRAIN : RUN;
            end
            RUN: begin
                if (last_i) state_d = DRAIN;
            end
            DRAIN: begin
                if (drain_q) state_d = DONE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge CLK_i) begin
        if (RST_i) begin
            state_q <= IDLE;
            drain_q <= 1'b0;
        end else begin
            state_q <= state_d;
            drain_q <= (state_q == DRAIN) && !drain_q;
        end
    end

    assign clear_o  = state_q == CLEAR;
    assign accept_o = (state_q == RUN) && sample_valid_i;
    assign busy_o   = (state_q == CLEAR) || (state_q == RUN) || (state_q == DRAIN);
    assign done_o   = state_q == DONE;

endmodule

`default_nettype wire

// ==== verilog/step_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_timer import mode_sweep_pkg::*; #(
    parameter int CNT_W = mode_sweep_pkg::CNT_W
) (
    input  wire logic             CLK_i,
    input  wire logic             RST_i,
    input  wire logic             load_i,
    input  wire logic             tick_i,
    input  wire logic [CNT_W-1:0] j_size_i,
    output logic                  last_o,
    output logic                  zero_size_o
);

    logic [CNT_W-1:0] size_q;
    logic [CNT_W-1:0] step_q;

    always_ff @(posedge CLK_i) begin
        if (RST_i) begin
            size_q <= '0;
            step_q <= '0;
        end else if (load_i) begin
            size_q <= j_size_i;
            step_q <= '0;
        end else if (tick_i) begin
            step_q <= step_q + 1'b1;
        end
    end

    // Tick that completes the run
    assign last_o      = tick_i && (step_q + 1'b1 == size_q);
    assign zero_size_o = size_q == '0;

    a_no_overrun: assert property (@(posedge CLK_i) disable iff (RST_i)
        tick_i |-> (step_q < size_q));

endmodule

`default_nettype wire

// ==== verilog/coef_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module coef_datapath import mode_sweep_pkg::*; #(
    parameter int INTERVALS = mode_sweep_pkg::INTERVALS
) (
    input  wire logic                            CLK_i,
    input  wire logic                            RST_i,
    lane_stage_if.dst                            stage_i [LANES],
    input  wire logic [LANES-1:0][INTERVALS-1:0] mode_i,
    output lane_data_t                           alpha_o,
    output lane_data_t                           beta_o,
    output lane_data_t                           alpha_s_o,
    output logic [LANES-1:0][INTERVALS-1:0]      interval_o,
    output logic                                 out_valid_o
);

    always_ff @(posedge CLK_i) begin
        if (RST_i) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= stage_i[0].valid;
        end
    end

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        data_t                       alpha_d;
        data_t                       beta_d;
        logic signed [2*WIDTH-1:0]   prod;
        logic                        mode_hit;
        data_t                       alpha_q;
        data_t                       beta_q;
        data_t                       alpha_s_q;
        logic [INTERVALS-1:0]        interval_q;

        // Wrapping Q8.8 differences
        assign alpha_d = stage_i[i].a_acc - stage_i[i].a_pos;
        assign beta_d  = stage_i[i].b_acc - stage_i[i].b_pos;

        // Q16.16 product, back to Q8.8 by truncation
        assign prod = alpha_d * stage_i[i].sample;

        // Mode as it stood before this sample
        assign mode_hit = stage_i[i].interval == mode_i[i];

        always_ff @(posedge CLK_i) begin
            if (stage_i[i].valid) begin
                alpha_q    <= mode_hit ? '0 : alpha_d;
                beta_q     <= mode_hit ? '0 : beta_d;
                alpha_s_q  <= mode_hit ? '0 : prod[WIDTH+FRAC_W-1:FRAC_W];
                interval_q <= stage_i[i].interval;
            end
        end

        assign alpha_o[i]    = alpha_q;
        assign beta_o[i]     = beta_q;
        assign alpha_s_o[i]  = alpha_s_q;
        assign interval_o[i] = interval_q;
    end

endmodule

`default_nettype wire

// ==== verilog/mode_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mode_tracker import mode_sweep_pkg::*; #(
    parameter int INTERVALS = mode_sweep_pkg::INTERVALS,
    parameter int CNT_W     = mode_sweep_pkg::CNT_W
) (
    input  wire logic                            CLK_i,
    input  wire logic                            RST_i,
    input  wire logic                            clear_i,
    input  wire logic                            upd_i,
    input  wire logic [LANES-1:0][INTERVALS-1:0] interval_i,
    input  wire logic [LANES-1:0][CNT_W-1:0]     new_cnt_i,
    output logic [LANES-1:0][INTERVALS-1:0]      mode_o,
    output logic [LANES-1:0][CNT_W-1:0]          max_cnt_o,
    output logic [LANES-1:0]                     u_add_o
);

    logic [LANES-1:0][INTERVALS-1:0] mode_q;
    logic [LANES-1:0][CNT_W-1:0]     max_q;
    logic [LANES-1:0]                u_add_q;
    logic [LANES-1:0]                hit;

    // Strictly greater, so a tie keeps the older mode
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            hit[l] = new_cnt_i[l] > max_q[l];
        end
    end

    always_ff @(posedge CLK_i) begin
        if (RST_i || clear_i) begin
            mode_q <= '0;
            max_q  <= '0;
        end else if (upd_i) begin
            for (int l = 0; l < LANES; l++) begin
                if (hit[l]) begin
                    mode_q[l] <= interval_i[l];
                    max_q[l]  <= new_cnt_i[l];
                end
            end
        end
    end

    // Pulses with the output edge only
    always_ff @(posedge CLK_i) begin
        if (RST_i) begin
            u_add_q <= '0;
        end else begin
            u_add_q <= upd_i ? hit : '0;
        end
    end

    assign mode_o    = mode_q;
    assign max_cnt_o = max_q;
    assign u_add_o   = u_add_q;

endmodule

`default_nettype wire

// ==== verilog/interval_histogram.sv ====
`timescale 1ns/1ps
`default_nettype none

module interval_histogram import mode_sweep_pkg::*; #(
    parameter int INTERVALS = mode_sweep_pkg::INTERVALS,
    parameter int CNT_W     = mode_sweep_pkg::CNT_W
) (
    input  wire logic                        CLK_i,
    input  wire logic                        RST_i,
    input  wire logic                        clear_i,
    lane_stage_if.dst                        stage_i [LANES],
    output logic [LANES-1:0][CNT_W-1:0]      new_cnt_o,
    output logic                             upd_o
);

    // Both lanes share one strobe
    assign upd_o = stage_i[0].valid;

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        logic [CNT_W-1:0] cnt_q [INTERVALS];
        logic [CNT_W-1:0] sel_cnt;

        ////////////////////////////////////////////////////////////
        // Counter select and increment
        ////////////////////////////////////////////////////////////

        always_comb begin
            sel_cnt = '0;
            for (int n = 0; n < INTERVALS; n++) begin
                if (stage_i[i].interval[n]) begin
                    sel_cnt = cnt_q[n];
                end
            end
        end

        // Seen by the tracker before the write-back edge
        assign new_cnt_o[i] = sel_cnt + 1'b1;

        ////////////////////////////////////////////////////////////
        // Write-back
        ////////////////////////////////////////////////////////////

        always_ff @(posedge CLK_i) begin
            if (RST_i || clear_i) begin
                for (int n = 0; n < INTERVALS; n++) begin
                    cnt_q[n] <= '0;
                end
            end else if (stage_i[i].valid) begin
                for (int n = 0; n < INTERVALS; n++) begin
                    if (stage_i[i].interval[n]) begin
                        cnt_q[n] <= new_cnt_o[i];
                    end
                end
            end
        end

        a_no_wrap: assert property (@(posedge CLK_i) disable iff (RST_i)
            stage_i[i].valid |-> (sel_cnt != {CNT_W{1'b1}}));
    end

endmodule

`default_nettype wire

// ==== verilog/interval_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module interval_classifier import mode_sweep_pkg::*; #(
    parameter int INTERVALS = mode_sweep_pkg::INTERVALS
) (
    input  wire logic       CLK_i,
    input  wire logic       RST_i,
    input  wire logic       accept_i,
    input  wire lane_data_t s_i,
    input  wire lane_data_t a_acc_i,
    input  wire lane_data_t a_pos_i,
    input  wire lane_data_t b_acc_i,
    input  wire lane_data_t b_pos_i,
    lane_stage_if.src       stage_o [LANES]
);

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        logic [INTERVALS-1:0] onehot;
        int                   k;

        // Integer part of the sample, centred on the middle interval
        always_comb begin
            k = int'($signed(s_i[i]) >>> FRAC_W) + INTERVALS / 2;
            onehot = '0;
            if (k < 0) begin
                onehot[0] = 1'b1;
            end else if (k > INTERVALS - 1) begin
                onehot[INTERVALS-1] = 1'b1;
            end else begin
                onehot[k] = 1'b1;
            end
        end

        always_ff @(posedge CLK_i) begin
            if (RST_i) begin
                stage_o[i].valid <= 1'b0;
            end else begin
                stage_o[i].valid <= accept_i;
            end
        end

        // Payload follows the strobe
        always_ff @(posedge CLK_i) begin
            stage_o[i].interval <= onehot;
            stage_o[i].sample   <= s_i[i];
            stage_o[i].a_acc    <= a_acc_i[i];
            stage_o[i].a_pos    <= a_pos_i[i];
            stage_o[i].b_acc    <= b_acc_i[i];
            stage_o[i].b_pos    <= b_pos_i[i];
        end

        a_onehot: assert property (@(posedge CLK_i) disable iff (RST_i)
            stage_o[i].valid |-> $onehot(stage_o[i].interval));
    end

endmodule

`default_nettype wire

// ==== verilog/lane_stage_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Registered stage-1 bundle of one lane
interface lane_stage_if import mode_sweep_pkg::*; ();

    logic    valid;
    onehot_t interval;
    data_t   sample;
    data_t   a_acc;
    data_t   a_pos;
    data_t   b_acc;
    data_t   b_pos;

    // Classifier side
    modport src (
        output valid, interval, sample, a_acc, a_pos, b_acc, b_pos
    );

    // Histogram and coefficient side
    modport dst (
        input valid, interval, sample, a_acc, a_pos, b_acc, b_pos
    );

endinterface

`default_nettype wire

// ==== verilog/mode_sweep_pkg.sv ====
`default_nettype none

package mode_sweep_pkg;

    ////////////////////////////////////////////////////////////
    // Data format and lane geometry
    ////////////////////////////////////////////////////////////

    // Q8.8 signed samples and coefficients
    localparam int WIDTH     = 16;
    localparam int FRAC_W    = 8;

    localparam int LANES     = 2;
    localparam int INTERVALS = 8;

    // Histogram counters and step count
    localparam int CNT_W     = 16;

    ////////////////////////////////////////////////////////////
    // Shared word types
    ////////////////////////////////////////////////////////////

    typedef logic signed [WIDTH-1:0] data_t;
    typedef data_t [LANES-1:0]       lane_data_t;
    typedef logic [INTERVALS-1:0]    onehot_t;
    typedef logic [CNT_W-1:0]        cnt_t;

    // Sweep sequencing
    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        RUN,
        DRAIN,
        DONE
    } sweep_state_e;

endpackage

`default_nettype wire
